// File: logic/hub75_pkg.sv
package hub75_pkg;

    // panel geometry
    localparam int PIXEL_WIDTH = 16;
    localparam int PIXEL_HEIGHT = 8;
    localparam int PIXEL_HALFHEIGHT = 4;   // rows per half-panel
    localparam int COL_BITS = 4;
    localparam int ROW_BITS = 2;
    localparam int BYTES_PER_PIXEL = 2;
    localparam int FB_ADDR_BITS = 8;       // row * 32 + col * 2 + byte

    // brightness planes and on-time
    localparam int BRIGHTNESS_LEVELS = 5;
    localparam int ON_CNT_BITS = 7;        // wide enough for the plane 4 on-time
    localparam logic [ON_CNT_BITS-1:0] BASE_ON_CYCLES = 4;

    // serial input
    localparam int CLKS_PER_BIT = 8;

    // command bytes
    localparam logic [7:0] CMD_LINE = 8'h4c;       // 'L'
    localparam logic [7:0] CMD_RGB_EN = 8'h45;     // 'E'
    localparam logic [7:0] CMD_BRIGHT_EN = 8'h4d;  // 'M'

    typedef logic [COL_BITS-1:0] col_t;
    typedef logic [ROW_BITS-1:0] row_t;

    // one framebuffer word, seen as bytes by the writer and as rgb565 by the scanner
    typedef union packed {
        logic [0:1][7:0] bytes;    // bytes[0] is the high byte
        struct packed {
            logic [4:0] red;
            logic [5:0] green;
            logic [4:0] blue;
        } color;
    } pixel_word_t;

endpackage

// File: logic/pixel_fetch_if.sv
interface pixel_fetch_if;

    hub75_pkg::col_t col;
    hub75_pkg::row_t half_row;
    logic load_start;                      // one cycle, answered two cycles later
    hub75_pkg::pixel_word_t pixel_top;
    hub75_pkg::pixel_word_t pixel_bottom;

    modport scan (
        output col, half_row, load_start,
        input  pixel_top, pixel_bottom
    );

    modport fetch (
        input  col, half_row, load_start,
        output pixel_top, pixel_bottom
    );

endinterface

// File: logic/uart_rx.sv
module uart_rx (
    input  logic       clk_root,
    input  logic       arst_n,
    input  logic       rx,
    output logic [7:0] data,
    output logic       valid
);

    logic rx_meta;
    logic rx_sync;
    logic busy;
    logic [3:0] bit_idx;    // 0 start, 1 to 8 data, 9 stop
    logic [$clog2(hub75_pkg::CLKS_PER_BIT)-1:0] tick;
    logic sample;

    // first sample in the middle of the start bit, then one per bit time
    assign sample = (bit_idx == 4'd0) ? int'(tick) == hub75_pkg::CLKS_PER_BIT / 2 - 1
                                      : int'(tick) == hub75_pkg::CLKS_PER_BIT - 1;

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            rx_meta <= 1'b1;    // idle line is high
            rx_sync <= 1'b1;
            busy <= 1'b0;
            bit_idx <= '0;
            tick <= '0;
            valid <= 1'b0;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            valid <= 1'b0;
            if (!busy) begin
                if (!rx_sync) begin     // start edge
                    busy <= 1'b1;
                    bit_idx <= '0;
                    tick <= '0;
                end
            end else if (!sample) begin
                tick <= tick + 1'b1;
            end else begin
                tick <= '0;
                bit_idx <= bit_idx + 1'b1;
                if (bit_idx == 4'd0 && rx_sync) begin
                    busy <= 1'b0;       // glitch, not a start bit
                end else if (bit_idx == 4'd9) begin
                    busy <= 1'b0;
                    valid <= rx_sync;   // bad stop bit drops the frame
                end
            end
        end
    end

    // lsb first
    always_ff @(posedge clk_root) begin
        if (busy && sample && bit_idx != 4'd0 && bit_idx != 4'd9) begin
            data <= {rx_sync, data[7:1]};
        end
    end

endmodule

// File: logic/control_module.sv
module control_module (
    input  logic                                    clk_root,
    input  logic                                    arst_n,
    input  logic [7:0]                              rx_data,
    input  logic                                    rx_valid,
    output logic [hub75_pkg::FB_ADDR_BITS-1:0]      wr_addr,
    output logic [7:0]                              wr_data,
    output logic                                    wr_en,
    output logic [2:0]                              rgb_enable,
    output logic [hub75_pkg::BRIGHTNESS_LEVELS-1:0] brightness_enable
);

    logic [7:0] cmd;        // command being served
    logic busy;             // past the command byte
    logic have_row;         // row byte of an L seen
    logic [7:0] row_sel;
    logic [hub75_pkg::COL_BITS:0] byte_cnt;    // 32 bytes per line
    logic line_data;

    assign line_data = rx_valid && busy && cmd == hub75_pkg::CMD_LINE && have_row;

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            cmd <= '0;
            busy <= 1'b0;
            have_row <= 1'b0;
            row_sel <= '0;
            byte_cnt <= '0;
            wr_en <= 1'b0;
            rgb_enable <= '1;
            brightness_enable <= '1;
        end else begin
            wr_en <= 1'b0;
            if (rx_valid) begin
                if (!busy) begin
                    cmd <= rx_data;
                    have_row <= 1'b0;
                    busy <= rx_data == hub75_pkg::CMD_LINE ||
                            rx_data == hub75_pkg::CMD_RGB_EN ||
                            rx_data == hub75_pkg::CMD_BRIGHT_EN;   // others ignored
                end else if (cmd == hub75_pkg::CMD_LINE && !have_row) begin
                    row_sel <= rx_data;
                    have_row <= 1'b1;
                    byte_cnt <= '0;
                end else if (cmd == hub75_pkg::CMD_LINE) begin
                    // rows past the panel are consumed but not stored
                    wr_en <= int'(row_sel) < hub75_pkg::PIXEL_HEIGHT;
                    byte_cnt <= byte_cnt + 1'b1;
                    if (&byte_cnt) begin
                        busy <= 1'b0;
                    end
                end else begin
                    if (cmd == hub75_pkg::CMD_RGB_EN) begin
                        rgb_enable <= rx_data[2:0];
                    end else begin
                        brightness_enable <= rx_data[hub75_pkg::BRIGHTNESS_LEVELS-1:0];
                    end
                    busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk_root) begin
        if (line_data) begin
            wr_addr <= {row_sel[hub75_pkg::ROW_BITS:0], byte_cnt};
            wr_data <= rx_data;
        end
    end

    // a write lands only in the commanded row on the panel
    a_wr_in_panel: assert property (@(posedge clk_root) disable iff (!arst_n)
        wr_en |-> int'(wr_addr) / (hub75_pkg::PIXEL_WIDTH * hub75_pkg::BYTES_PER_PIXEL) ==
                  int'(row_sel));

endmodule

// File: logic/framebuffer_ram.sv
module framebuffer_ram (
    input  logic                                           clk_root,
    input  logic [hub75_pkg::FB_ADDR_BITS-1:0]             wr_addr,
    input  logic [7:0]                                     wr_data,
    input  logic                                           wr_en,
    input  logic [hub75_pkg::ROW_BITS+hub75_pkg::COL_BITS-1:0] rd_addr,
    output hub75_pkg::pixel_word_t                         rd_top,
    output hub75_pkg::pixel_word_t                         rd_bottom
);

    hub75_pkg::pixel_word_t top_mem [hub75_pkg::PIXEL_HALFHEIGHT*hub75_pkg::PIXEL_WIDTH];
    hub75_pkg::pixel_word_t bottom_mem [hub75_pkg::PIXEL_HALFHEIGHT*hub75_pkg::PIXEL_WIDTH];

    logic bank_sel;     // row bit 2 picks the half-panel
    logic [hub75_pkg::ROW_BITS+hub75_pkg::COL_BITS-1:0] wr_word;
    logic byte_sel;

    assign bank_sel = wr_addr[hub75_pkg::FB_ADDR_BITS-1];
    assign wr_word = wr_addr[hub75_pkg::FB_ADDR_BITS-2:1];
    assign byte_sel = wr_addr[0];

    always_ff @(posedge clk_root) begin
        if (wr_en && !bank_sel) top_mem[wr_word].bytes[byte_sel] <= wr_data;
        if (wr_en && bank_sel) bottom_mem[wr_word].bytes[byte_sel] <= wr_data;
        rd_top <= top_mem[rd_addr];         // same position in both banks
        rd_bottom <= bottom_mem[rd_addr];
    end

endmodule

// File: logic/framebuffer_fetch.sv
module framebuffer_fetch (
    input  logic                                               clk_root,
    input  logic                                               arst_n,
    pixel_fetch_if.fetch                                       fetch,
    output logic [hub75_pkg::ROW_BITS+hub75_pkg::COL_BITS-1:0] rd_addr,
    input  hub75_pkg::pixel_word_t                             rd_top,
    input  hub75_pkg::pixel_word_t                             rd_bottom
);

    logic load_d1;  // ram data valid this cycle

    // word index within a half-panel
    assign rd_addr = {fetch.half_row, fetch.col};

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            load_d1 <= 1'b0;
        end else begin
            load_d1 <= fetch.load_start;
        end
    end

    // pixels land two cycles after the request
    always_ff @(posedge clk_root) begin
        if (load_d1) begin
            fetch.pixel_top <= rd_top;
            fetch.pixel_bottom <= rd_bottom;
        end
    end

endmodule

// File: logic/matrix_scan.sv
module matrix_scan (
    input  logic                                    clk_root,
    input  logic                                    arst_n,
    pixel_fetch_if.scan                             scan,
    input  logic [2:0]                              rgb_enable,
    input  logic [hub75_pkg::BRIGHTNESS_LEVELS-1:0] brightness_enable,
    output logic [2:0]                              rgb_top,
    output logic [2:0]                              rgb_bottom,
    output hub75_pkg::row_t                         row_addr,
    output logic                                    clk_pixel,
    output logic                                    row_latch,
    output logic                                    oe_n
);

    logic shifting;
    logic [1:0] phase;      // four cycles per column
    hub75_pkg::col_t col;
    logic [$clog2(hub75_pkg::BRIGHTNESS_LEVELS)-1:0] plane;
    hub75_pkg::row_t row;
    logic [hub75_pkg::ON_CNT_BITS-1:0] on_cnt;
    logic [2:0] plane_mask;

    // bit (width - 5 + b) of each channel, so green drops its lsb
    function automatic logic [2:0] plane_bits(hub75_pkg::pixel_word_t px,
                                              logic [$clog2(hub75_pkg::BRIGHTNESS_LEVELS)-1:0] b);
        plane_bits = {px.color.red[b], px.color.green[b + 1], px.color.blue[b]};
    endfunction

    assign scan.col = col;
    assign scan.half_row = row;
    assign scan.load_start = shifting && phase == 2'd0;

    assign plane_mask = rgb_enable & {3{brightness_enable[plane]}};
    assign rgb_top = plane_bits(scan.pixel_top, plane) & plane_mask;
    assign rgb_bottom = plane_bits(scan.pixel_bottom, plane) & plane_mask;

    always_ff @(posedge clk_root or negedge arst_n) begin
        if (!arst_n) begin
            shifting <= 1'b1;
            phase <= '0;
            col <= '0;
            plane <= '0;
            row <= '0;
            on_cnt <= '0;
            row_addr <= '0;
            clk_pixel <= 1'b0;
            row_latch <= 1'b0;
            oe_n <= 1'b1;
        end else begin
            clk_pixel <= shifting && phase == 2'd2;     // rises once data is stable
            row_latch <= 1'b0;
            if (shifting) begin
                phase <= phase + 1'b1;
                if (phase == 2'd3) begin
                    col <= col + 1'b1;
                    if (int'(col) == hub75_pkg::PIXEL_WIDTH - 1) begin
                        shifting <= 1'b0;
                        row_latch <= 1'b1;
                        row_addr <= row;
                        on_cnt <= hub75_pkg::BASE_ON_CYCLES << plane;   // binary weight
                    end
                end
            end else if (row_latch) begin
                oe_n <= 1'b0;
            end else if (!oe_n) begin
                on_cnt <= on_cnt - 1'b1;
                if (int'(on_cnt) == 1) begin
                    oe_n <= 1'b1;
                end
            end else begin
                // blank cycle over, next plane
                shifting <= 1'b1;
                if (int'(plane) == hub75_pkg::BRIGHTNESS_LEVELS - 1) begin
                    plane <= '0;
                    row <= row + 1'b1;
                end else begin
                    plane <= plane + 1'b1;
                end
            end
        end
    end

    a_oe_blank: assert property (@(posedge clk_root) disable iff (!arst_n)
        (clk_pixel || row_latch) |-> oe_n);

    a_latch_pulse: assert property (@(posedge clk_root) disable iff (!arst_n)
        row_latch |=> !row_latch);

endmodule

// File: logic/hub75_top.sv
module hub75_top (
    input  logic            clk_root,
    input  logic            arst_n,
    input  logic            uart_rx,
    output logic [2:0]      rgb_top,
    output logic [2:0]      rgb_bottom,
    output hub75_pkg::row_t row_addr,
    output logic            clk_pixel,
    output logic            row_latch,
    output logic            oe_n
);

    logic [7:0] rx_data;
    logic rx_valid;
    logic [hub75_pkg::FB_ADDR_BITS-1:0] wr_addr;
    logic [7:0] wr_data;
    logic wr_en;
    logic [2:0] rgb_enable;
    logic [hub75_pkg::BRIGHTNESS_LEVELS-1:0] brightness_enable;
    logic [hub75_pkg::ROW_BITS+hub75_pkg::COL_BITS-1:0] rd_addr;
    hub75_pkg::pixel_word_t rd_top;
    hub75_pkg::pixel_word_t rd_bottom;

    pixel_fetch_if pix_if ();

    uart_rx rx_inst (
        .clk_root (clk_root),
        .arst_n   (arst_n),
        .rx       (uart_rx),
        .data     (rx_data),
        .valid    (rx_valid)
    );

    control_module ctrl (
        .clk_root          (clk_root),
        .arst_n            (arst_n),
        .rx_data           (rx_data),
        .rx_valid          (rx_valid),
        .wr_addr           (wr_addr),
        .wr_data           (wr_data),
        .wr_en             (wr_en),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable)
    );

    framebuffer_ram fb (
        .clk_root  (clk_root),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_en     (wr_en),
        .rd_addr   (rd_addr),
        .rd_top    (rd_top),
        .rd_bottom (rd_bottom)
    );

    framebuffer_fetch fb_f (
        .clk_root  (clk_root),
        .arst_n    (arst_n),
        .fetch     (pix_if.fetch),
        .rd_addr   (rd_addr),
        .rd_top    (rd_top),
        .rd_bottom (rd_bottom)
    );

    matrix_scan matscan (
        .clk_root          (clk_root),
        .arst_n            (arst_n),
        .scan              (pix_if.scan),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable),
        .rgb_top           (rgb_top),
        .rgb_bottom        (rgb_bottom),
        .row_addr          (row_addr),
        .clk_pixel         (clk_pixel),
        .row_latch         (row_latch),
        .oe_n              (oe_n)
    );

endmodule

// File: bench/hub75_tb.sv
module hub75_tb;

    localparam int LINE_BYTES = 2 + hub75_pkg::PIXEL_WIDTH * hub75_pkg::BYTES_PER_PIXEL;
    localparam int TOTAL_BYTES = 9 * LINE_BYTES + 9;    // 8 lines, E, E+M, M+X, one more line
    localparam int WINDOWS = 4;
    localparam int FRAME_CYCLES = hub75_pkg::PIXEL_HALFHEIGHT *
        (hub75_pkg::BRIGHTNESS_LEVELS * (4 * hub75_pkg::PIXEL_WIDTH + 2) +
         int'(hub75_pkg::BASE_ON_CYCLES) * ((1 << hub75_pkg::BRIGHTNESS_LEVELS) - 1));
    // each window waits for a latch, then one frame; three frames leave margin
    localparam int CYCLE_LIMIT = TOTAL_BYTES * 10 * hub75_pkg::CLKS_PER_BIT +
                                 3 * WINDOWS * FRAME_CYCLES;

    logic clk_root = 1'b0;
    logic arst_n = 1'b0;
    logic uart_rx = 1'b1;   // idle line
    logic [2:0] rgb_top;
    logic [2:0] rgb_bottom;
    hub75_pkg::row_t row_addr;
    logic clk_pixel;
    logic row_latch;
    logic oe_n;

    int seed = 84598;
    int cycle_count = 0;
    logic checking = 1'b0;

    // what the panel should hold
    hub75_pkg::pixel_word_t fb_model [hub75_pkg::PIXEL_HEIGHT][hub75_pkg::PIXEL_WIDTH];
    logic [2:0] rgb_en_model = 3'b111;
    logic [hub75_pkg::BRIGHTNESS_LEVELS-1:0] bright_en_model = '1;

    // monitor state
    int col_cnt = 0;
    int mon_plane = 0;
    int on_plane = 0;
    hub75_pkg::row_t mon_row = '0;
    logic [hub75_pkg::ON_CNT_BITS-1:0] on_len = '0;
    logic on_due = 1'b0;    // latch seen, its on-time not yet

    hub75_top UUT (
        .clk_root   (clk_root),
        .arst_n     (arst_n),
        .uart_rx    (uart_rx),
        .rgb_top    (rgb_top),
        .rgb_bottom (rgb_bottom),
        .row_addr   (row_addr),
        .clk_pixel  (clk_pixel),
        .row_latch  (row_latch),
        .oe_n       (oe_n)
    );

    always #5 clk_root = ~clk_root;

    task automatic abort_run(string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic rgb_compare(string name, logic [2:0] got, logic [2:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("ERROR at %0t: %s got %b, expected %b", $time, name, got, exp));
        end
    endtask

    task automatic row_compare(string name, hub75_pkg::row_t got, hub75_pkg::row_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERROR at %0t: %s got %0d, expected %0d", $time, name, got, exp));
        end
    endtask

    task automatic on_time_compare(string name, logic [hub75_pkg::ON_CNT_BITS-1:0] got,
                                   logic [hub75_pkg::ON_CNT_BITS-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("ERROR at %0t: %s got %0d, expected %0d", $time, name, got, exp));
        end
    endtask

    // plane b takes bit (width - 5 + b) of each channel, then both masks
    function automatic logic [2:0] expected_bits(hub75_pkg::pixel_word_t px, logic [2:0] rgb_en,
                                                 logic [hub75_pkg::BRIGHTNESS_LEVELS-1:0] bright_en,
                                                 int plane);
        logic [2:0] raw;
        raw = {px.color.red[$bits(px.color.red) - 5 + plane],
               px.color.green[$bits(px.color.green) - 5 + plane],
               px.color.blue[$bits(px.color.blue) - 5 + plane]};
        return raw & rgb_en & {3{bright_en[plane]}};
    endfunction

    // 8N1, lsb first
    task automatic send_byte(logic [7:0] value);
        logic [9:0] frame;
        frame = {1'b1, value, 1'b0};
        for (int i = 0; i < 10; i++) begin
            uart_rx <= frame[i];
            repeat (hub75_pkg::CLKS_PER_BIT) @(posedge clk_root);
        end
    endtask

    task automatic send_line(int row);
        logic [31:0] rnd;
        send_byte(hub75_pkg::CMD_LINE);
        send_byte(8'(row));
        for (int col = 0; col < hub75_pkg::PIXEL_WIDTH; col++) begin
            for (int b = 0; b < hub75_pkg::BYTES_PER_PIXEL; b++) begin
                rnd = $random(seed);
                fb_model[row][col].bytes[b] = rnd[7:0];     // high byte first
                send_byte(rnd[7:0]);
            end
        end
    endtask

    // compare one full frame, starting at the next latch
    task automatic scan_window();
        int latches;
        latches = 0;
        do begin
            @(posedge clk_root);
        end while (!row_latch);
        checking <= 1'b1;
        while (latches < hub75_pkg::PIXEL_HALFHEIGHT * hub75_pkg::BRIGHTNESS_LEVELS) begin
            @(posedge clk_root);
            if (row_latch) latches++;
        end
        checking <= 1'b0;
    endtask

    always @(posedge clk_root) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            abort_run("timeout: the run went past its cycle limit");
        end
    end

    // panel monitor, sees the pins as they were just before the edge
    always @(posedge clk_root) begin
        if (arst_n) begin
            if (clk_pixel && !oe_n) abort_run("oe_n was low while clk_pixel was high");
            if (clk_pixel) begin
                if (checking) begin
                    rgb_compare($sformatf("rgb_top row %0d col %0d plane %0d",
                                          mon_row, col_cnt, mon_plane), rgb_top,
                                expected_bits(fb_model[int'(mon_row)][col_cnt],
                                              rgb_en_model, bright_en_model, mon_plane));
                    rgb_compare($sformatf("rgb_bottom row %0d col %0d plane %0d",
                                          mon_row, col_cnt, mon_plane), rgb_bottom,
                                expected_bits(fb_model[int'(mon_row) + hub75_pkg::PIXEL_HALFHEIGHT]
                                                      [col_cnt],
                                              rgb_en_model, bright_en_model, mon_plane));
                end
                col_cnt++;
            end
            if (row_latch) begin
                if (col_cnt != hub75_pkg::PIXEL_WIDTH) begin
                    abort_run("row_latch did not come after exactly 16 clk_pixel pulses");
                end
                if (on_due) begin
                    abort_run("oe_n did not go low after the previous row_latch");
                end
                row_compare("row_addr", row_addr, mon_row);
                on_plane = mon_plane;
                on_due = 1'b1;
                if (mon_plane == hub75_pkg::BRIGHTNESS_LEVELS - 1) begin
                    mon_plane = 0;
                    mon_row = mon_row + 1'b1;
                end else begin
                    mon_plane++;
                end
                col_cnt = 0;
            end
            if (!oe_n) begin
                on_len = on_len + 1'b1;
            end else if (on_len != 0) begin
                on_time_compare("oe_n low cycles", on_len, hub75_pkg::BASE_ON_CYCLES << on_plane);
                on_len = '0;
                on_due = 1'b0;
            end
        end
    end

    initial begin
        repeat (4) @(posedge clk_root);
        arst_n <= 1'b1;
        @(posedge clk_root);

        // whole panel
        for (int r = 0; r < hub75_pkg::PIXEL_HEIGHT; r++) begin
            send_line(r);
        end
        repeat (2 * hub75_pkg::CLKS_PER_BIT) @(posedge clk_root);
        scan_window();

        // green off
        send_byte(hub75_pkg::CMD_RGB_EN);
        send_byte(8'h05);
        rgb_en_model = 3'b101;
        repeat (2 * hub75_pkg::CLKS_PER_BIT) @(posedge clk_root);
        scan_window();

        // all colours back, only planes 1 and 2
        send_byte(hub75_pkg::CMD_RGB_EN);
        send_byte(8'h07);
        send_byte(hub75_pkg::CMD_BRIGHT_EN);
        send_byte(8'h06);
        rgb_en_model = 3'b111;
        bright_en_model = 5'b00110;
        repeat (2 * hub75_pkg::CLKS_PER_BIT) @(posedge clk_root);
        scan_window();

        // unknown 'X' in command position, then a fresh row 5
        send_byte(hub75_pkg::CMD_BRIGHT_EN);
        send_byte(8'h1f);
        send_byte(8'h58);
        send_line(5);
        bright_en_model = '1;
        repeat (2 * hub75_pkg::CLKS_PER_BIT) @(posedge clk_root);
        scan_window();

        $display("all tests passed");
        $finish;
    end

endmodule

// File: project.f
logic/hub75_pkg.sv
logic/pixel_fetch_if.sv
logic/uart_rx.sv
logic/control_module.sv
logic/framebuffer_ram.sv
logic/framebuffer_fetch.sv
logic/matrix_scan.sv
logic/hub75_top.sv
bench/hub75_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= hub75_tb
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert
PASS_TEXT ?= all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# pass only when the testbench prints the pass line
run: build
	@out=$$($(BUILD_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
